/* design/fc_pkg.sv */
package fc_pkg;

    // layer shape
    localparam int IN_FEATURES  = 120;
    localparam int OUT_FEATURES = 84;

    // int8 elements per cycle, two 32-bit words of four bytes each
    localparam int LANES       = 8;
    localparam int ISSUE_STEPS = IN_FEATURES / LANES;

    // word layout in the two SRAMs
    localparam int ROW_STRIDE = ISSUE_STEPS * 2;
    localparam int OUT_BASE   = IN_FEATURES / 4;

    // SRAM read pipeline depth
    localparam int READ_LATENCY = 3;

    // requantization
    localparam int QUANT_SHIFT = 16;

    // bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int ACC_W  = 32;

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        DRAIN,
        WRITE,
        FLUSH,
        DONE
    } fc_state_t;

endpackage

/* design/fc_step_if.sv */
`timescale 1ns/1ps

interface fc_step_if;

    // strobes from the controller
    logic issue_en;
    logic acc_en;
    logic acc_clr;
    logic write_en;

    // flags and indices from the counters
    logic issue_last;
    logic drain_last;
    logic out_last;
    logic [fc_pkg::ADDR_W-1:0] in_idx;
    logic [fc_pkg::ADDR_W-1:0] row_idx;
    logic [fc_pkg::ADDR_W-1:0] out_idx;

    modport ctrl (
        output issue_en, acc_en, acc_clr, write_en,
        input  issue_last, drain_last, out_last
    );

    modport cnt (
        input  issue_en, write_en,
        output issue_last, drain_last, out_last, in_idx, row_idx, out_idx
    );

    modport dp_addr (input issue_en, write_en, in_idx, row_idx, out_idx);

    modport dp_mac (input acc_en, acc_clr);

endinterface

/* design/fc_ctrl.sv */
`timescale 1ns/1ps

module fc_ctrl (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    fc_step_if.ctrl   step,
    output logic      finish
);

    localparam int RL = fc_pkg::READ_LATENCY;

    fc_pkg::fc_state_t state;
    fc_pkg::fc_state_t state_next;

    logic          flush_cnt;
    logic [RL-1:0] issue_pipe;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fc_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // second FLUSH cycle marker
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_cnt <= 1'b0;
        end else if (state == fc_pkg::FLUSH) begin
            flush_cnt <= !flush_cnt;
        end else begin
            flush_cnt <= 1'b0;
        end
    end

    // rdata lags the address by the SRAM latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_pipe <= '0;
        end else begin
            issue_pipe <= {issue_pipe[RL-2:0], step.issue_en};
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            fc_pkg::IDLE: begin
                if (start) begin
                    state_next = fc_pkg::ISSUE;
                end
            end
            fc_pkg::ISSUE: begin
                if (step.issue_last) begin
                    state_next = fc_pkg::DRAIN;
                end
            end
            fc_pkg::DRAIN: begin
                if (step.drain_last) begin
                    state_next = fc_pkg::WRITE;
                end
            end
            fc_pkg::WRITE: begin
                if (step.out_last) begin
                    state_next = fc_pkg::FLUSH;
                end else begin
                    state_next = fc_pkg::ISSUE;
                end
            end
            fc_pkg::FLUSH: begin
                if (flush_cnt) begin
                    state_next = fc_pkg::DONE;
                end
            end
            fc_pkg::DONE: begin
                state_next = fc_pkg::DONE;
            end
            default: begin
                state_next = fc_pkg::IDLE;
            end
        endcase
    end

    assign step.issue_en = (state == fc_pkg::ISSUE);
    assign step.acc_en   = issue_pipe[RL-1];
    assign step.write_en = (state == fc_pkg::WRITE);
    // accumulator is consumed by the write, cleared behind it
    assign step.acc_clr  = (state == fc_pkg::WRITE);
    assign finish        = (state == fc_pkg::DONE);

endmodule

/* design/fc_counters.sv */
`timescale 1ns/1ps

module fc_counters #(
    parameter int IN_FEATURES  = fc_pkg::IN_FEATURES,
    parameter int OUT_FEATURES = fc_pkg::OUT_FEATURES
) (
    input  logic   clk,
    input  logic   rst_n,
    fc_step_if.cnt step
);

    localparam int AW = fc_pkg::ADDR_W;
    localparam int TW = $clog2(fc_pkg::READ_LATENCY);

    localparam logic [AW-1:0] IN_STEP    = AW'(fc_pkg::LANES);
    localparam logic [AW-1:0] IN_LAST    = AW'(IN_FEATURES - fc_pkg::LANES);
    localparam logic [AW-1:0] OUT_LAST   = AW'(OUT_FEATURES - 1);
    localparam logic [TW-1:0] DRAIN_LAST = TW'(fc_pkg::READ_LATENCY - 1);

    logic          drain_active;
    logic [TW-1:0] drain_cnt;

    assign step.issue_last = (step.in_idx == IN_LAST);
    assign step.out_last   = (step.out_idx == OUT_LAST);
    assign step.drain_last = drain_active && (drain_cnt == DRAIN_LAST);

    // element index within the current row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step.in_idx <= '0;
        end else if (step.issue_en) begin
            if (step.issue_last) begin
                step.in_idx <= '0;
            end else begin
                step.in_idx <= step.in_idx + IN_STEP;
            end
        end
    end

    // neuron indices move on each result write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step.row_idx <= '0;
            step.out_idx <= '0;
        end else if (step.write_en) begin
            if (step.out_last) begin
                step.row_idx <= '0;
                step.out_idx <= '0;
            end else begin
                step.row_idx <= step.row_idx + 1'b1;
                step.out_idx <= step.out_idx + 1'b1;
            end
        end
    end

    // drain timer, armed by the last issue of a row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_active <= 1'b0;
        end else if (step.drain_last) begin
            drain_active <= 1'b0;
        end else if (step.issue_en && step.issue_last) begin
            drain_active <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_cnt <= '0;
        end else if (drain_active && !step.drain_last) begin
            drain_cnt <= drain_cnt + 1'b1;
        end else begin
            drain_cnt <= '0;
        end
    end

endmodule

/* design/fc_addr_gen.sv */
`timescale 1ns/1ps

module fc_addr_gen #(
    parameter int ROW_STRIDE = fc_pkg::ROW_STRIDE,
    parameter int OUT_BASE   = fc_pkg::OUT_BASE
) (
    input  logic [fc_pkg::ADDR_W-1:0]   weight_offset,
    input  logic [fc_pkg::ADDR_W-1:0]   act_offset,
    fc_step_if.dp_addr                  step,
    input  logic [7:0]                  quant,
    output logic                        weight_cen,
    output logic                        act_cen,
    output logic [fc_pkg::ADDR_W-1:0]   weight_addr0,
    output logic [fc_pkg::ADDR_W-1:0]   weight_addr1,
    output logic [fc_pkg::ADDR_W-1:0]   act_addr0,
    output logic [fc_pkg::ADDR_W-1:0]   act_addr1,
    output logic [fc_pkg::DATA_W/8-1:0] act_wea0,
    output logic [fc_pkg::DATA_W-1:0]   act_wdata0
);

    localparam int AW = fc_pkg::ADDR_W;
    localparam int DW = fc_pkg::DATA_W;

    localparam logic [AW-1:0] STRIDE  = AW'(ROW_STRIDE);
    localparam logic [AW-1:0] OUT_OFS = AW'(OUT_BASE);

    logic [AW-1:0] in_word;
    logic [AW-1:0] weight_word;
    logic [AW-1:0] act_word;
    logic [AW-1:0] out_word;
    logic [1:0]    out_lane;

    // four int8 elements per word
    assign in_word     = {2'b00, step.in_idx[AW-1:2]};
    assign weight_word = weight_offset + step.row_idx * STRIDE + in_word;
    assign act_word    = act_offset + in_word;
    assign out_word    = act_offset + OUT_OFS + {2'b00, step.out_idx[AW-1:2]};
    assign out_lane    = step.out_idx[1:0];

    always_comb begin
        weight_cen   = 1'b1;
        act_cen      = 1'b1;
        weight_addr0 = '0;
        weight_addr1 = '0;
        act_addr0    = '0;
        act_addr1    = '0;
        act_wea0     = '0;
        act_wdata0   = '0;
        if (step.issue_en) begin
            weight_cen   = 1'b0;
            act_cen      = 1'b0;
            weight_addr0 = weight_word;
            weight_addr1 = weight_word + 1'b1;
            act_addr0    = act_word;
            act_addr1    = act_word + 1'b1;
        end else if (step.write_en) begin
            // single byte lane on port 0
            act_cen            = 1'b0;
            act_addr0          = out_word;
            act_wea0[out_lane] = 1'b1;
            act_wdata0         = {{(DW-8){1'b0}}, quant} << {out_lane, 3'b000};
        end
    end

endmodule

/* design/fc_mac.sv */
`timescale 1ns/1ps

module fc_mac (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [fc_pkg::DATA_W-1:0]         weight_rdata0,
    input  logic [fc_pkg::DATA_W-1:0]         weight_rdata1,
    input  logic [fc_pkg::DATA_W-1:0]         act_rdata0,
    input  logic [fc_pkg::DATA_W-1:0]         act_rdata1,
    fc_step_if.dp_mac                         step,
    output logic signed [fc_pkg::ACC_W-1:0]   acc
);

    localparam int AW = fc_pkg::ACC_W;
    localparam int VW = 2 * fc_pkg::DATA_W;

    logic [VW-1:0]        w_vec;
    logic [VW-1:0]        a_vec;
    logic signed [AW-1:0] dot;

    // word 0 carries elements k..k+3, low byte first
    assign w_vec = {weight_rdata1, weight_rdata0};
    assign a_vec = {act_rdata1, act_rdata0};

    always_comb begin
        dot = '0;
        for (int i = 0; i < fc_pkg::LANES; i++) begin
            dot = dot + AW'($signed(w_vec[8*i +: 8]) * $signed(a_vec[8*i +: 8]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (step.acc_clr) begin
            acc <= '0;
        end else if (step.acc_en) begin
            acc <= acc + dot;
        end
    end

endmodule

/* design/fc_requant.sv */
`timescale 1ns/1ps

module fc_requant (
    input  logic signed [fc_pkg::ACC_W-1:0] acc,
    input  logic [fc_pkg::DATA_W-1:0]       scale,
    output logic [7:0]                      quant
);

    localparam int AW = fc_pkg::ACC_W;
    localparam int PW = fc_pkg::ACC_W + fc_pkg::DATA_W;

    localparam logic [PW-1:0] QMAX = PW'(127);

    logic [AW-1:0] relu;
    logic [PW-1:0] scaled;
    logic [PW-1:0] shifted;

    assign relu = acc[AW-1] ? '0 : acc;

    // full-width product, no overflow before the shift
    assign scaled  = relu * scale;
    assign shifted = scaled >>> fc_pkg::QUANT_SHIFT;

    // saturate into the positive int8 range
    assign quant = (shifted > QMAX) ? QMAX[7:0] : shifted[7:0];

endmodule

/* design/fc_layer.sv */
`timescale 1ns/1ps

module fc_layer #(
    parameter int IN_FEATURES  = fc_pkg::IN_FEATURES,
    parameter int OUT_FEATURES = fc_pkg::OUT_FEATURES,
    parameter int ROW_STRIDE   = fc_pkg::ROW_STRIDE,
    parameter int OUT_BASE     = fc_pkg::OUT_BASE
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    output logic                        finish,

    input  logic [fc_pkg::ADDR_W-1:0]   weight_offset,
    input  logic [fc_pkg::ADDR_W-1:0]   act_offset,
    input  logic [fc_pkg::DATA_W-1:0]   scale,

    // weight SRAM, read only
    output logic                        weight_cen,
    output logic [fc_pkg::ADDR_W-1:0]   weight_addr0,
    output logic [fc_pkg::ADDR_W-1:0]   weight_addr1,
    input  logic [fc_pkg::DATA_W-1:0]   weight_rdata0,
    input  logic [fc_pkg::DATA_W-1:0]   weight_rdata1,

    // activation SRAM, results go back through port 0
    output logic                        act_cen,
    output logic [fc_pkg::DATA_W/8-1:0] act_wea0,
    output logic [fc_pkg::ADDR_W-1:0]   act_addr0,
    output logic [fc_pkg::ADDR_W-1:0]   act_addr1,
    output logic [fc_pkg::DATA_W-1:0]   act_wdata0,
    input  logic [fc_pkg::DATA_W-1:0]   act_rdata0,
    input  logic [fc_pkg::DATA_W-1:0]   act_rdata1
);

    logic signed [fc_pkg::ACC_W-1:0] acc;
    logic [7:0]                      quant;

    fc_step_if step_bus ();

    fc_ctrl ctrl_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .step   (step_bus.ctrl),
        .finish (finish)
    );

    fc_counters #(
        .IN_FEATURES  (IN_FEATURES),
        .OUT_FEATURES (OUT_FEATURES)
    ) counters_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (step_bus.cnt)
    );

    fc_addr_gen #(
        .ROW_STRIDE (ROW_STRIDE),
        .OUT_BASE   (OUT_BASE)
    ) addr_gen_inst (
        .weight_offset (weight_offset),
        .act_offset    (act_offset),
        .step          (step_bus.dp_addr),
        .quant         (quant),
        .weight_cen    (weight_cen),
        .act_cen       (act_cen),
        .weight_addr0  (weight_addr0),
        .weight_addr1  (weight_addr1),
        .act_addr0     (act_addr0),
        .act_addr1     (act_addr1),
        .act_wea0      (act_wea0),
        .act_wdata0    (act_wdata0)
    );

    fc_mac mac_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .weight_rdata0 (weight_rdata0),
        .weight_rdata1 (weight_rdata1),
        .act_rdata0    (act_rdata0),
        .act_rdata1    (act_rdata1),
        .step          (step_bus.dp_mac),
        .acc           (acc)
    );

    fc_requant requant_inst (
        .acc   (acc),
        .scale (scale),
        .quant (quant)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

/* tests/fc_sram_model.sv */
`timescale 1ns/1ps

module fc_sram_model #(
    parameter int DEPTH   = 4096,
    parameter int LATENCY = fc_pkg::READ_LATENCY,
    parameter int AW      = fc_pkg::ADDR_W,
    parameter int DW      = fc_pkg::DATA_W
) (
    input  logic            clk,
    input  logic            cen,
    input  logic [DW/8-1:0] wea0,
    input  logic [AW-1:0]   addr0,
    input  logic [AW-1:0]   addr1,
    input  logic [DW-1:0]   wdata0,
    output logic [DW-1:0]   rdata0,
    output logic [DW-1:0]   rdata1
);

    localparam int IW = $clog2(DEPTH);

    logic [DW-1:0] mem [DEPTH];
    logic [DW-1:0] pipe0 [LATENCY];
    logic [DW-1:0] pipe1 [LATENCY];

    // read data moves one stage per cycle, write after read on port 0
    always @(posedge clk) begin
        if (!cen) begin
            pipe0[0] <= mem[addr0[IW-1:0]];
            pipe1[0] <= mem[addr1[IW-1:0]];
        end
        for (int s = 1; s < LATENCY; s++) begin
            pipe0[s] <= pipe0[s-1];
            pipe1[s] <= pipe1[s-1];
        end
        if (!cen) begin
            for (int b = 0; b < DW / 8; b++) begin
                if (wea0[b]) begin
                    mem[addr0[IW-1:0]][8*b +: 8] <= wdata0[8*b +: 8];
                end
            end
        end
    end

    assign rdata0 = pipe0[LATENCY-1];
    assign rdata1 = pipe1[LATENCY-1];

endmodule

/* tests/fc_layer_tb.sv */
`timescale 1ns/1ps

module fc_layer_tb;

    localparam int IN_F      = fc_pkg::IN_FEATURES;
    localparam int OUT_F     = fc_pkg::OUT_FEATURES;
    localparam int OUT_BASE  = fc_pkg::OUT_BASE;
    localparam int OUT_WORDS = OUT_F / 4;
    localparam int MEM_DEPTH = 4096;

    // issue, drain and one write per neuron, then two flush cycles
    localparam int NEURON_CYCLES  = fc_pkg::ISSUE_STEPS + fc_pkg::READ_LATENCY + 1;
    localparam int LAYER_CYCLES   = 1 + OUT_F * NEURON_CYCLES + 2;
    localparam int TIMEOUT_CYCLES = 2 * LAYER_CYCLES + 802;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        finish;
    logic [15:0] weight_offset;
    logic [15:0] act_offset;
    logic [31:0] scale;
    logic        weight_cen;
    logic [15:0] weight_addr0;
    logic [15:0] weight_addr1;
    logic [31:0] weight_rdata0;
    logic [31:0] weight_rdata1;
    logic        act_cen;
    logic [3:0]  act_wea0;
    logic [15:0] act_addr0;
    logic [15:0] act_addr1;
    logic [31:0] act_wdata0;
    logic [31:0] act_rdata0;
    logic [31:0] act_rdata1;

    integer      seed;
    int          cyc = 0;
    int          write_count;
    int          write_errs;
    int          finish_errs;
    int          start_cycle;
    int          finish_cycle;
    int          tests_passed;
    int          tests_failed;
    int          run_a_ofs;
    logic [31:0] w_img [MEM_DEPTH];
    logic [31:0] a_img [MEM_DEPTH];
    logic [7:0]  exp_out [OUT_F];

    tb_clock #(.PERIOD_NS(40.0)) clock_inst (.clk(clk));

    fc_layer fc_layer_inst (.*);

    fc_sram_model #(.DEPTH(MEM_DEPTH)) weight_sram_inst (
        .clk    (clk),
        .cen    (weight_cen),
        .wea0   (4'b0000),
        .addr0  (weight_addr0),
        .addr1  (weight_addr1),
        .wdata0 (32'h0),
        .rdata0 (weight_rdata0),
        .rdata1 (weight_rdata1)
    );

    fc_sram_model #(.DEPTH(MEM_DEPTH)) act_sram_inst (
        .clk    (clk),
        .cen    (act_cen),
        .wea0   (act_wea0),
        .addr0  (act_addr0),
        .addr1  (act_addr1),
        .wdata0 (act_wdata0),
        .rdata0 (act_rdata0),
        .rdata1 (act_rdata1)
    );

    // one neuron: int8 dot product, relu, unsigned scale, shift, clamp
    function automatic logic [7:0] ref_neuron(input int n, input int w_ofs, input int a_ofs,
                                              input logic [31:0] scl);
        logic [31:0] w_word;
        logic [31:0] a_word;
        byte         w_b;
        byte         a_b;
        int          sum;
        logic [63:0] prod;
        sum = 0;
        for (int i = 0; i < IN_F; i++) begin
            w_word = w_img[w_ofs + n * fc_pkg::ROW_STRIDE + i / 4];
            a_word = a_img[a_ofs + i / 4];
            w_b = w_word[8 * (i % 4) +: 8];
            a_b = a_word[8 * (i % 4) +: 8];
            sum += int'(w_b) * int'(a_b);
        end
        if (sum < 0) begin
            sum = 0;
        end
        prod = (64'(sum) * 64'(scl)) >> fc_pkg::QUANT_SHIFT;
        return (prod > 64'd127) ? 8'd127 : prod[7:0];
    endfunction

    function automatic int count_mismatch(input string name, input logic [63:0] got,
                                          input logic [63:0] exp);
        int result;
        result = 0;
        assert (got === exp) else begin
            $display("[FAIL] %s got %0h expected %0h", name, got, exp);
            result = 1;
        end
        return result;
    endfunction

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, errs);
        end
    endtask

    task automatic fill_images(input bit biased, input int w_ofs, input int a_ofs);
        int idx;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            w_img[i] = $random(seed);
            a_img[i] = $random(seed);
        end
        // non-negative inputs, even rows negative and odd rows positive
        if (biased) begin
            for (int i = 0; i < IN_F / 4; i++) begin
                a_img[a_ofs + i] = a_img[a_ofs + i] & 32'h7f7f7f7f;
            end
            for (int n = 0; n < OUT_F; n++) begin
                for (int i = 0; i < IN_F / 4; i++) begin
                    idx = w_ofs + n * fc_pkg::ROW_STRIDE + i;
                    if (n % 2 == 0) begin
                        w_img[idx] = w_img[idx] | 32'h80808080;
                    end else begin
                        w_img[idx] = w_img[idx] & 32'h7f7f7f7f;
                    end
                end
            end
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            weight_sram_inst.mem[i] = w_img[i];
            act_sram_inst.mem[i]    = a_img[i];
        end
    endtask

    task automatic compute_expected(input int w_ofs, input int a_ofs, input logic [31:0] scl);
        for (int n = 0; n < OUT_F; n++) begin
            exp_out[n] = ref_neuron(n, w_ofs, a_ofs, scl);
        end
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic check_idle_outputs(input string name);
        int errs;
        errs = 0;
        @(negedge clk);
        errs += count_mismatch("finish", finish, 1'b0);
        errs += count_mismatch("weight_cen", weight_cen, 1'b1);
        errs += count_mismatch("act_cen", act_cen, 1'b1);
        errs += count_mismatch("act_wea0", act_wea0, 4'h0);
        errs += count_mismatch("weight_addr0", weight_addr0, 16'h0);
        errs += count_mismatch("weight_addr1", weight_addr1, 16'h0);
        errs += count_mismatch("act_addr0", act_addr0, 16'h0);
        errs += count_mismatch("act_addr1", act_addr1, 16'h0);
        errs += count_mismatch("act_wdata0", act_wdata0, 32'h0);
        report_test(name, errs);
    endtask

    task automatic check_outputs(input string tag, input int a_ofs, input bit need_extremes);
        int          errs;
        int          ofs;
        int          zeros;
        int          sats;
        logic [31:0] got;
        errs  = 0;
        zeros = 0;
        sats  = 0;
        for (int n = 0; n < OUT_F; n++) begin
            got = act_sram_inst.mem[a_ofs + OUT_BASE + n / 4];
            errs += count_mismatch($sformatf("act_sram byte %0d", n),
                                   got[8 * (n % 4) +: 8], exp_out[n]);
            zeros += (got[8 * (n % 4) +: 8] == 8'd0);
            sats  += (got[8 * (n % 4) +: 8] == 8'd127);
        end
        // everything outside the result words stays as loaded
        for (int i = 0; i < MEM_DEPTH; i++) begin
            ofs = i - a_ofs - OUT_BASE;
            if (ofs < 0 || ofs >= OUT_WORDS) begin
                errs += count_mismatch($sformatf("act_sram word %0d", i),
                                       act_sram_inst.mem[i], a_img[i]);
            end
        end
        if (need_extremes) begin
            assert (zeros > 0 && sats > 0) else begin
                $display("outputs do not include both a zero and a saturated byte");
                errs++;
            end
        end
        report_test({tag, "_outputs"}, errs);
    endtask

    task automatic run_layer(input string tag, input int w_ofs, input int a_ofs,
                             input logic [31:0] scl, input bit need_extremes);
        int errs;
        run_a_ofs = a_ofs;
        @(posedge clk);
        weight_offset <= 16'(w_ofs);
        act_offset    <= 16'(a_ofs);
        scale         <= scl;
        start         <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do @(negedge clk); while (!finish);
        repeat (8) @(negedge clk);
        errs = finish_errs;
        assert (start_cycle >= 0 && finish_cycle >= 0) else begin
            $display("start or finish was never observed");
            errs++;
        end
        if (start_cycle >= 0 && finish_cycle >= 0) begin
            errs += count_mismatch("finish delay", finish_cycle - start_cycle, LAYER_CYCLES);
        end
        report_test({tag, "_finish"}, errs);
        errs = write_errs + count_mismatch("write count", write_count, OUT_F);
        report_test({tag, "_writes"}, errs);
        check_outputs(tag, a_ofs, need_extremes);
    endtask

    // result writes and finish level, checked as they happen
    always @(posedge clk) begin : write_monitor
        int lane;
        if (!rst_n) begin
            write_count  = 0;
            write_errs   = 0;
            finish_errs  = 0;
            start_cycle  = -1;
            finish_cycle = -1;
        end else begin
            if (start && start_cycle < 0) begin
                start_cycle = cyc;
            end
            if (finish && finish_cycle < 0) begin
                finish_cycle = cyc;
            end
            assert (finish || finish_cycle < 0) else begin
                $display("finish dropped before the next reset");
                finish_errs++;
            end
            if (act_wea0 != 4'h0) begin
                lane = write_count % 4;
                assert (write_count < OUT_F) else begin
                    $display("result write after the last neuron");
                    write_errs++;
                end
                if (write_count < OUT_F) begin
                    write_errs += count_mismatch("act_cen", act_cen, 1'b0);
                    write_errs += count_mismatch("act_addr0", act_addr0,
                                                 16'(run_a_ofs + OUT_BASE + write_count / 4));
                    write_errs += count_mismatch("act_wea0", act_wea0, 4'b0001 << lane);
                    write_errs += count_mismatch("act_wdata0", act_wdata0[8 * lane +: 8],
                                                 exp_out[write_count]);
                end
                write_count++;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the layer never completed", cyc);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        seed          = 32'h53aa7468;
        tests_passed  = 0;
        tests_failed  = 0;
        run_a_ofs     = 0;
        rst_n         = 1'b0;
        start         = 1'b0;
        weight_offset = 16'h0;
        act_offset    = 16'h0;
        scale         = 32'h0;

        // random int8 data, mid-range scale
        fill_images(1'b0, 'h100, 'h40);
        compute_expected('h100, 'h40, 32'h0000_0060);
        apply_reset();
        check_idle_outputs("reset_1");
        run_layer("run1", 'h100, 'h40, 32'h0000_0060, 1'b0);

        // biased data so results hit both zero and saturation
        fill_images(1'b1, 'h400, 'h200);
        compute_expected('h400, 'h200, 32'h8000_0000);
        @(posedge clk);
        apply_reset();
        check_idle_outputs("reset_2");
        run_layer("run2", 'h400, 'h200, 32'h8000_0000, 1'b1);

        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
design/fc_pkg.sv
design/fc_step_if.sv
design/fc_ctrl.sv
design/fc_counters.sv
design/fc_addr_gen.sv
design/fc_mac.sv
design/fc_requant.sv
design/fc_layer.sv
tests/tb_clock.sv
tests/fc_sram_model.sv
tests/fc_layer_tb.sv
